//--- design/cache_pkg.sv
package cache_pkg;

    // ==================================================
    // fixed cache geometry
    // ==================================================
    localparam int num_ways = 4;  // way masks are one-hot over this many ways
    localparam int word_w   = 32;

    // ==================================================
    // controller states and cache operations
    // ==================================================
    typedef enum logic [1:0] {
        st_idle,
        st_lookup,
        st_replace,  // one setup cycle that clears the refill counter
        st_refill
    } ctrl_state_e;

    typedef enum logic [1:0] {
        op_none,
        op_index_inv,  // way picked by the two lowest address bits
        op_hit_inv
    } cacop_e;

endpackage

//--- design/wb_pkg.sv
package wb_pkg;

    // classic read-only bus, one word per cycle
    localparam int wb_adr_w = 32;
    localparam int wb_dat_w = 32;

endpackage

//--- design/refill_counter.sv
`timescale 1ns/1ps

module refill_counter #(
    parameter int offset_bits = 2
) (
    input  logic                   clk,
    input  logic                   rstn,
    input  logic                   refill_start,
    input  logic                   beat_done,
    output logic [offset_bits-1:0] word_offset,
    output logic                   fill_finish
);

    logic [offset_bits-1:0] count_q;
    logic                   last_q;

    assign word_offset = count_q;
    assign fill_finish = last_q;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            count_q <= '0;
            last_q  <= 1'b0;
        end else if (refill_start) begin
            count_q <= '0;
            last_q  <= 1'b0;
        end else begin
            last_q <= beat_done && (count_q == {offset_bits{1'b1}});  // high one cycle after the last beat
            if (beat_done) begin
                count_q <= count_q + 1'b1;  // wraps back to zero after the last word
            end
        end
    end

endmodule

//--- design/tag_store.sv
`timescale 1ns/1ps

module tag_store
    import cache_pkg::*;
    import wb_pkg::*;
#(
    parameter int index_bits  = 4,
    parameter int offset_bits = 2
) (
    input  logic                                       clk,
    input  logic                                       rstn,
    input  logic [index_bits-1:0]                      lookup_index,
    input  logic [wb_adr_w-index_bits-offset_bits-3:0] lookup_tag,
    input  logic [num_ways-1:0]                        tag_we,
    input  logic [num_ways-1:0]                        tag_clear,
    output logic [num_ways-1:0]                        hit_way,
    output logic [num_ways-1:0]                        victim_way
);

    localparam int sets  = 1 << index_bits;
    localparam int tag_w = wb_adr_w - index_bits - offset_bits - 2;
    localparam int ptr_w = $clog2(num_ways);

    logic [tag_w-1:0]              tag_q [num_ways][sets];
    logic [num_ways-1:0][sets-1:0] valid_q;
    logic [sets-1:0][ptr_w-1:0]    ptr_q;  // round-robin victim per set

    always_comb begin
        for (int w = 0; w < num_ways; w++) begin
            hit_way[w] = valid_q[w][lookup_index] && (tag_q[w][lookup_index] == lookup_tag);
        end
    end

    assign victim_way = {{(num_ways-1){1'b0}}, 1'b1} << ptr_q[lookup_index];

    always_ff @(posedge clk) begin
        if (!rstn) begin
            valid_q <= '0;
            ptr_q   <= '0;
        end else begin
            for (int w = 0; w < num_ways; w++) begin
                if (tag_we[w]) begin
                    valid_q[w][lookup_index] <= 1'b1;
                end else if (tag_clear[w]) begin
                    valid_q[w][lookup_index] <= 1'b0;
                end
            end
            if (|tag_we) begin
                ptr_q[lookup_index] <= ptr_q[lookup_index] + ptr_w'(1);  // next fill takes the next way
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int w = 0; w < num_ways; w++) begin
            if (tag_we[w]) begin
                tag_q[w][lookup_index] <= lookup_tag;
            end
        end
    end

endmodule

//--- design/line_store.sv
`timescale 1ns/1ps

module line_store
    import cache_pkg::*;
#(
    parameter int index_bits  = 4,
    parameter int offset_bits = 2
) (
    input  logic                   clk,
    input  logic [index_bits-1:0]  lookup_index,
    input  logic [offset_bits-1:0] fill_offset,
    input  logic [num_ways-1:0]    line_we,
    input  logic [word_w-1:0]      fill_data,
    input  logic [num_ways-1:0]    hit_way,
    input  logic [offset_bits-1:0] word_select,
    output logic [word_w-1:0]      hit_data
);

    localparam int sets  = 1 << index_bits;
    localparam int words = 1 << offset_bits;

    logic [word_w-1:0] mem_q [num_ways][sets][words];

    always_ff @(posedge clk) begin
        for (int w = 0; w < num_ways; w++) begin
            if (line_we[w]) begin
                mem_q[w][lookup_index][fill_offset] <= fill_data;
            end
        end
    end

    // hit_way is one-hot, so an or-reduction is enough for the mux
    always_comb begin
        hit_data = '0;
        for (int w = 0; w < num_ways; w++) begin
            if (hit_way[w]) begin
                hit_data = hit_data | mem_q[w][lookup_index][word_select];
            end
        end
    end

endmodule

//--- design/icache_ctrl.sv
`timescale 1ns/1ps

module icache_ctrl
    import cache_pkg::*;
    import wb_pkg::*;
#(
    parameter int index_bits  = 4,
    parameter int offset_bits = 2
) (
    input  logic                                       clk,
    input  logic                                       rstn,
    input  logic                                       valid,
    input  logic [wb_adr_w-1:0]                        addr,
    input  logic                                       uncache,
    input  logic                                       cacop_en,
    input  cacop_e                                     cacop_code,
    input  logic [num_ways-1:0]                        hit_way,
    input  logic [num_ways-1:0]                        victim_way,
    input  logic [word_w-1:0]                          hit_data,
    input  logic [offset_bits-1:0]                     word_offset,
    input  logic                                       fill_finish,
    input  logic [wb_dat_w-1:0]                        wb_dat_i,
    input  logic                                       wb_ack,
    output logic                                       cache_ready,
    output logic                                       data_valid,
    output logic [word_w-1:0]                          rdata,
    output logic                                       wb_cyc,
    output logic                                       wb_stb,
    output logic [wb_adr_w-1:0]                        wb_adr,
    output logic                                       refill_start,
    output logic                                       beat_done,
    output logic [index_bits-1:0]                      lookup_index,
    output logic [wb_adr_w-index_bits-offset_bits-3:0] lookup_tag,
    output logic [num_ways-1:0]                        tag_we,
    output logic [num_ways-1:0]                        tag_clear,
    output logic [num_ways-1:0]                        line_we,
    output logic [offset_bits-1:0]                     fill_offset,
    output logic [word_w-1:0]                          fill_data,
    output logic [offset_bits-1:0]                     word_select
);

    localparam int tag_lsb = index_bits + offset_bits + 2;

    ctrl_state_e state_q, state_d;

    logic [wb_adr_w-1:0]    req_addr;
    logic                   req_uncache;
    logic                   req_cacop;
    cacop_e                 req_code;
    logic [word_w-1:0]      req_word;  // requested word caught during refill
    logic [offset_bits-1:0] req_offset;
    logic                   hit;
    logic                   last_beat;

    assign hit        = |hit_way;
    assign req_offset = req_addr[offset_bits+1:2];
    assign last_beat  = beat_done && (word_offset == {offset_bits{1'b1}});

    assign lookup_index = req_addr[tag_lsb-1:offset_bits+2];
    assign lookup_tag   = req_addr[wb_adr_w-1:tag_lsb];
    assign word_select  = req_offset;
    assign fill_offset  = word_offset;
    assign fill_data    = wb_dat_i;
    assign wb_adr       = req_uncache ? req_addr
                        : {req_addr[wb_adr_w-1:offset_bits+2], word_offset, 2'b00};

    // ==================================================
    // request buffer
    // ==================================================
    always_ff @(posedge clk) begin
        if (valid && cache_ready) begin
            req_addr    <= addr;
            req_uncache <= uncache;
            req_cacop   <= cacop_en && (cacop_code != op_none);
            req_code    <= cacop_code;
        end
    end

    always_ff @(posedge clk) begin
        if (beat_done && (word_offset == req_offset)) begin
            req_word <= wb_dat_i;
        end
    end

    // ==================================================
    // main FSM
    // ==================================================
    always_ff @(posedge clk) begin
        if (!rstn) begin
            state_q <= st_idle;
        end else begin
            state_q <= state_d;
        end
    end

    always_comb begin
        state_d      = state_q;
        cache_ready  = 1'b0;
        data_valid   = 1'b0;
        rdata        = hit_data;
        wb_cyc       = 1'b0;
        wb_stb       = 1'b0;
        refill_start = 1'b0;
        beat_done    = 1'b0;
        tag_we       = '0;
        tag_clear    = '0;
        line_we      = '0;
        unique case (state_q)
            st_idle: begin
                cache_ready = 1'b1;
                if (valid) begin
                    state_d = st_lookup;
                end
            end
            st_lookup: begin
                if (req_cacop) begin
                    data_valid  = 1'b1;  // rdata is don't-care here
                    cache_ready = 1'b1;
                    tag_clear   = (req_code == op_index_inv)
                                ? {{(num_ways-1){1'b0}}, 1'b1} << req_addr[1:0] : hit_way;
                    state_d     = valid ? st_lookup : st_idle;
                end else if (req_uncache || !hit) begin
                    state_d = st_replace;
                end else begin
                    data_valid  = 1'b1;
                    cache_ready = 1'b1;  // keeps back-to-back hits at one per cycle
                    state_d     = valid ? st_lookup : st_idle;
                end
            end
            st_replace: begin
                refill_start = 1'b1;
                state_d      = st_refill;
            end
            st_refill: begin
                wb_cyc    = req_uncache || !fill_finish;  // strobe drops after the last beat
                wb_stb    = wb_cyc;
                beat_done = wb_stb && wb_ack;
                if (req_uncache) begin
                    if (wb_ack) begin
                        data_valid  = 1'b1;
                        cache_ready = 1'b1;
                        rdata       = wb_dat_i;
                        state_d     = valid ? st_lookup : st_idle;
                    end
                end else begin
                    line_we = beat_done ? victim_way : '0;
                    tag_we  = last_beat ? victim_way : '0;
                    if (fill_finish) begin
                        data_valid  = 1'b1;
                        cache_ready = 1'b1;
                        rdata       = req_word;
                        state_d     = valid ? st_lookup : st_idle;
                    end
                end
            end
        endcase
    end

endmodule

//--- design/icache_top.sv
`timescale 1ns/1ps

module icache_top
    import cache_pkg::*;
    import wb_pkg::*;
#(
    parameter int index_bits  = 4,
    parameter int offset_bits = 2
) (
    input  logic                clk,
    input  logic                rstn,
    input  logic                valid,
    input  logic [wb_adr_w-1:0] addr,
    input  logic                uncache,
    input  logic                cacop_en,
    input  cacop_e              cacop_code,
    output logic                cache_ready,
    output logic                data_valid,
    output logic [word_w-1:0]   rdata,
    output logic                wb_cyc,
    output logic                wb_stb,
    output logic [wb_adr_w-1:0] wb_adr,
    input  logic [wb_dat_w-1:0] wb_dat_i,
    input  logic                wb_ack
);

    localparam int tag_w = wb_adr_w - index_bits - offset_bits - 2;

    logic                   refill_start;
    logic                   beat_done;
    logic [offset_bits-1:0] word_offset;
    logic                   fill_finish;
    logic [index_bits-1:0]  lookup_index;
    logic [tag_w-1:0]       lookup_tag;
    logic [num_ways-1:0]    tag_we;
    logic [num_ways-1:0]    tag_clear;
    logic [num_ways-1:0]    hit_way;
    logic [num_ways-1:0]    victim_way;
    logic [num_ways-1:0]    line_we;
    logic [offset_bits-1:0] fill_offset;
    logic [word_w-1:0]      fill_data;
    logic [offset_bits-1:0] word_select;
    logic [word_w-1:0]      hit_data;

    icache_ctrl #(
        .index_bits  (index_bits),
        .offset_bits (offset_bits)
    ) i_icache_ctrl (
        .clk          (clk),
        .rstn         (rstn),
        .valid        (valid),
        .addr         (addr),
        .uncache      (uncache),
        .cacop_en     (cacop_en),
        .cacop_code   (cacop_code),
        .hit_way      (hit_way),
        .victim_way   (victim_way),
        .hit_data     (hit_data),
        .word_offset  (word_offset),
        .fill_finish  (fill_finish),
        .wb_dat_i     (wb_dat_i),
        .wb_ack       (wb_ack),
        .cache_ready  (cache_ready),
        .data_valid   (data_valid),
        .rdata        (rdata),
        .wb_cyc       (wb_cyc),
        .wb_stb       (wb_stb),
        .wb_adr       (wb_adr),
        .refill_start (refill_start),
        .beat_done    (beat_done),
        .lookup_index (lookup_index),
        .lookup_tag   (lookup_tag),
        .tag_we       (tag_we),
        .tag_clear    (tag_clear),
        .line_we      (line_we),
        .fill_offset  (fill_offset),
        .fill_data    (fill_data),
        .word_select  (word_select)
    );

    refill_counter #(
        .offset_bits (offset_bits)
    ) i_refill_counter (
        .clk          (clk),
        .rstn         (rstn),
        .refill_start (refill_start),
        .beat_done    (beat_done),
        .word_offset  (word_offset),
        .fill_finish  (fill_finish)
    );

    tag_store #(
        .index_bits  (index_bits),
        .offset_bits (offset_bits)
    ) i_tag_store (
        .clk          (clk),
        .rstn         (rstn),
        .lookup_index (lookup_index),
        .lookup_tag   (lookup_tag),
        .tag_we       (tag_we),
        .tag_clear    (tag_clear),
        .hit_way      (hit_way),
        .victim_way   (victim_way)
    );

    line_store #(
        .index_bits  (index_bits),
        .offset_bits (offset_bits)
    ) i_line_store (
        .clk          (clk),
        .lookup_index (lookup_index),
        .fill_offset  (fill_offset),
        .line_we      (line_we),
        .fill_data    (fill_data),
        .hit_way      (hit_way),
        .word_select  (word_select),
        .hit_data     (hit_data)
    );

endmodule

//--- test/icache_properties.sv
`timescale 1ns/1ps

module icache_properties
    import cache_pkg::*;
    import wb_pkg::*;
(
    input logic                clk,
    input logic                rstn,
    input ctrl_state_e         state_q,
    input logic                wb_cyc,
    input logic                wb_stb,
    input logic                wb_ack,
    input logic [wb_adr_w-1:0] wb_adr,
    input logic                data_valid
);

    stb_needs_cyc: assert property (@(posedge clk) disable iff (!rstn)
        (wb_stb && !wb_ack) |=> (wb_stb && wb_cyc))
        else $error("wb_stb or wb_cyc dropped before wb_ack");

    adr_held: assert property (@(posedge clk) disable iff (!rstn)
        (wb_stb && !wb_ack) |=> $stable(wb_adr))
        else $error("wb_adr changed while a bus cycle was waiting for wb_ack");

    // the refill response is a single pulse
    single_refill_pulse: assert property (@(posedge clk) disable iff (!rstn)
        (state_q == st_refill && data_valid) |=> !(state_q == st_refill && data_valid))
        else $error("data_valid high on two consecutive refill cycles");

    cyc_low_after_reset: assert property (@(posedge clk) !rstn |=> !wb_cyc)
        else $error("wb_cyc high right after reset");

endmodule

//--- test/icache_checker.sv
`timescale 1ns/1ps

module icache_checker
    import cache_pkg::*;
    import wb_pkg::*;
#(
    parameter int          offset_bits = 2,
    parameter logic [31:0] mem_pattern = 32'h0
) (
    input  logic                clk,
    input  logic                rstn,
    input  logic                valid,
    input  logic [wb_adr_w-1:0] addr,
    input  logic                uncache,
    input  logic                cacop_en,
    input  cacop_e              cacop_code,
    input  logic                cache_ready,
    input  logic                data_valid,
    input  logic [word_w-1:0]   rdata,
    input  logic                wb_cyc,
    input  logic                wb_stb,
    input  logic                wb_ack,
    input  logic [wb_adr_w-1:0] wb_adr,
    input  int                  exp_reads,
    input  int                  test_num,
    input  logic                report_req,
    output int                  error_count,
    output int                  tests_done
);

    localparam int line_bytes = 4 << offset_bits;

    logic                active;
    logic [wb_adr_w-1:0] acc_addr;
    logic                acc_uncache;
    logic                acc_cacop;
    cacop_e              acc_code;
    int                  acc_reads;
    int                  acc_test;
    int                  reads;
    int                  latency;
    int                  test_errors;
    int                  tests_failed;
    logic [wb_adr_w-1:0] exp_adr;
    logic [word_w-1:0]   exp_data;
    string               kind;

    // ==================================================
    // per-request bookkeeping
    // ==================================================
    task check_beat();
        exp_adr = acc_uncache ? acc_addr
                : (acc_addr & ~wb_adr_w'(line_bytes - 1)) + wb_adr_w'(reads * 4);  // refill walks the line
        if (wb_adr !== exp_adr) begin
            $display("Error test %0d: wb_adr = 0x%08h, expected 0x%08h", acc_test, wb_adr, exp_adr);
            test_errors++;
        end
        if (wb_cyc !== 1'b1) begin
            $display("Error test %0d: wb_cyc = 0x%0h, expected 0x1", acc_test, wb_cyc);
            test_errors++;
        end
        reads++;
    endtask

    task finish_test();
        if (!acc_cacop) begin
            exp_data = (acc_uncache ? acc_addr : {acc_addr[wb_adr_w-1:2], 2'b00}) ^ mem_pattern;
            if (rdata !== exp_data) begin
                $display("Error test %0d: rdata = 0x%08h, expected 0x%08h",
                         acc_test, rdata, exp_data);
                test_errors++;
            end
        end
        if (reads != acc_reads) begin
            $display("Error test %0d: bus read count = 0x%0h, expected 0x%0h",
                     acc_test, reads, acc_reads);
            test_errors++;
        end
        if (acc_reads == 0 && latency != 1) begin
            $display("test %0d: response came %0d cycles after acceptance instead of 1",
                     acc_test, latency);
            test_errors++;
        end
        if (acc_cacop) begin
            kind = acc_code.name();
        end else if (acc_uncache) begin
            kind = "read uncached";
        end else begin
            kind = "read";
        end
        $display("test %0d %s addr 0x%08h, %0d bus reads: %s",
                 acc_test, kind, acc_addr, reads, (test_errors == 0) ? "pass" : "fail");
        tests_done++;
        if (test_errors != 0) begin
            tests_failed++;
        end
        error_count += test_errors;
        active = 1'b0;
    endtask

    // all ports are sampled mid-cycle where they are settled
    always @(negedge clk) begin
        if (!rstn) begin
            active       = 1'b0;
            error_count  = 0;
            tests_done   = 0;
            tests_failed = 0;
        end else begin
            if (active) begin
                latency++;
                if (acc_reads == 0 && wb_cyc !== 1'b0) begin  // hits and cache ops stay off the bus
                    $display("Error test %0d: wb_cyc = 0x%0h, expected 0x0", acc_test, wb_cyc);
                    test_errors++;
                end
                if (wb_stb && wb_ack) begin
                    check_beat();
                end
                if (data_valid) begin
                    finish_test();
                end
            end else if (data_valid || wb_cyc || (wb_stb && wb_ack)) begin
                $display("bus cycle or data_valid seen with no request outstanding");
                error_count++;
            end
            if (valid && cache_ready) begin  // accepted at the coming edge
                active      = 1'b1;
                acc_addr    = addr;
                acc_uncache = uncache;
                acc_cacop   = cacop_en && (cacop_code != op_none);
                acc_code    = cacop_code;
                acc_reads   = exp_reads;
                acc_test    = test_num;
                reads       = 0;
                latency     = 0;
                test_errors = 0;
            end
            if (report_req) begin
                $display("tests %0d, failed %0d, errors %0d", tests_done, tests_failed, error_count);
            end
        end
    end

endmodule

//--- test/icache_tb.sv
`timescale 1ns/1ps

module icache_tb
    import cache_pkg::*;
    import wb_pkg::*;
();

    localparam int          index_bits  = 4;
    localparam int          offset_bits = 2;
    localparam int          words       = 1 << offset_bits;
    localparam logic [31:0] mem_pattern = 32'h5a5a_c3c3;
    localparam int          max_wait    = 100;  // cycles per wait loop

    logic                clk = 1'b0;
    logic                rstn;
    logic                valid;
    logic [wb_adr_w-1:0] addr;
    logic                uncache;
    logic                cacop_en;
    cacop_e              cacop_code;
    logic                cache_ready;
    logic                data_valid;
    logic [word_w-1:0]   rdata;
    logic                wb_cyc;
    logic                wb_stb;
    logic [wb_adr_w-1:0] wb_adr;
    logic [wb_dat_w-1:0] wb_dat_i;
    logic                wb_ack;

    int   exp_reads;
    int   test_num;
    logic report_req;
    int   error_count;
    int   tests_done;
    logic timed_out;

    cacop_e              op_q[$];
    logic [wb_adr_w-1:0] addr_q[$];
    logic                unc_q[$];
    int                  reads_q[$];

    int unsigned lcg_state = 28480;

    always #4 clk = ~clk;

    icache_top #(
        .index_bits  (index_bits),
        .offset_bits (offset_bits)
    ) i_icache_top (
        .clk         (clk),
        .rstn        (rstn),
        .valid       (valid),
        .addr        (addr),
        .uncache     (uncache),
        .cacop_en    (cacop_en),
        .cacop_code  (cacop_code),
        .cache_ready (cache_ready),
        .data_valid  (data_valid),
        .rdata       (rdata),
        .wb_cyc      (wb_cyc),
        .wb_stb      (wb_stb),
        .wb_adr      (wb_adr),
        .wb_dat_i    (wb_dat_i),
        .wb_ack      (wb_ack)
    );

    icache_checker #(
        .offset_bits (offset_bits),
        .mem_pattern (mem_pattern)
    ) i_icache_checker (
        .clk         (clk),
        .rstn        (rstn),
        .valid       (valid),
        .addr        (addr),
        .uncache     (uncache),
        .cacop_en    (cacop_en),
        .cacop_code  (cacop_code),
        .cache_ready (cache_ready),
        .data_valid  (data_valid),
        .rdata       (rdata),
        .wb_cyc      (wb_cyc),
        .wb_stb      (wb_stb),
        .wb_ack      (wb_ack),
        .wb_adr      (wb_adr),
        .exp_reads   (exp_reads),
        .test_num    (test_num),
        .report_req  (report_req),
        .error_count (error_count),
        .tests_done  (tests_done)
    );

    bind icache_ctrl icache_properties i_icache_properties (
        .clk        (clk),
        .rstn       (rstn),
        .state_q    (state_q),
        .wb_cyc     (wb_cyc),
        .wb_stb     (wb_stb),
        .wb_ack     (wb_ack),
        .wb_adr     (wb_adr),
        .data_valid (data_valid)
    );

    function automatic int unsigned next_random();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state >> 16;
    endfunction

    // ==================================================
    // Wishbone memory model
    // ==================================================
    initial begin
        int   wait_left;
        logic busy;
        wb_ack    = 1'b0;
        wb_dat_i  = '0;
        wait_left = 0;
        busy      = 1'b0;
        forever begin
            @(posedge clk);
            #1;
            wb_ack = 1'b0;
            if (rstn && wb_stb) begin
                if (!busy) begin
                    busy      = 1'b1;
                    wait_left = int'(next_random() % 4);  // 0 to 3 wait cycles per read
                end
                if (wait_left == 0) begin
                    wb_ack   = 1'b1;
                    wb_dat_i = wb_adr ^ mem_pattern;
                    busy     = 1'b0;
                end else begin
                    wait_left--;
                end
            end
        end
    end

    // ==================================================
    // stimulus table
    // ==================================================
    task automatic add_entry(input cacop_e op, input logic [wb_adr_w-1:0] a,
                             input logic unc, input int n);
        op_q.push_back(op);
        addr_q.push_back(a);
        unc_q.push_back(unc);
        reads_q.push_back(n);
    endtask

    task automatic load_table();
        // op, address, uncached, expected bus reads
        add_entry(op_none,      32'h0000_1004, 1'b0, words);  // cold miss in set 0
        add_entry(op_none,      32'h0000_100c, 1'b0, 0);
        add_entry(op_none,      32'h0000_1000, 1'b0, 0);
        add_entry(op_none,      32'h0000_2010, 1'b1, 1);
        add_entry(op_none,      32'h0000_2010, 1'b1, 1);
        add_entry(op_none,      32'h0001_0030, 1'b0, words);  // five tags into set 3
        add_entry(op_none,      32'h0002_0034, 1'b0, words);
        add_entry(op_none,      32'h0003_0038, 1'b0, words);
        add_entry(op_none,      32'h0004_003c, 1'b0, words);
        add_entry(op_none,      32'h0005_0030, 1'b0, words);  // evicts way 0
        add_entry(op_none,      32'h0005_0034, 1'b0, 0);
        add_entry(op_none,      32'h0001_0030, 1'b0, words);  // refills into way 1
        add_entry(op_none,      32'h0005_0038, 1'b0, 0);
        add_entry(op_none,      32'h0003_0038, 1'b0, 0);
        add_entry(op_none,      32'h0002_0034, 1'b0, words);
        add_entry(op_hit_inv,   32'h0000_1008, 1'b0, 0);
        add_entry(op_none,      32'h0000_1008, 1'b0, words);
        add_entry(op_index_inv, 32'h0000_0033, 1'b0, 0);      // set 3, way 3
        add_entry(op_none,      32'h0004_003c, 1'b0, words);
        add_entry(op_none,      32'h0005_0030, 1'b0, 0);
    endtask

    task automatic run_entry(input int idx);
        int cycles;
        test_num   = idx + 1;
        exp_reads  = reads_q[idx];
        valid      = 1'b1;
        addr       = addr_q[idx];
        uncache    = unc_q[idx];
        cacop_en   = (op_q[idx] != op_none);
        cacop_code = op_q[idx];
        cycles     = 0;
        @(negedge clk);
        while (!cache_ready && cycles < max_wait) begin
            @(negedge clk);
            cycles++;
        end
        if (!cache_ready) begin
            $display("timeout: cache_ready stayed low on test %0d", test_num);
            timed_out = 1'b1;
            return;
        end
        @(posedge clk);
        #1;
        valid      = 1'b0;
        uncache    = 1'b0;
        cacop_en   = 1'b0;
        cacop_code = op_none;
        cycles     = 0;
        @(negedge clk);
        while (!data_valid && cycles < max_wait) begin
            @(negedge clk);
            cycles++;
        end
        if (!data_valid) begin
            $display("timeout: no data_valid for test %0d", test_num);
            timed_out = 1'b1;
            return;
        end
        @(posedge clk);
        #1;
    endtask

    initial begin
        rstn       = 1'b0;
        valid      = 1'b0;
        addr       = '0;
        uncache    = 1'b0;
        cacop_en   = 1'b0;
        cacop_code = op_none;
        exp_reads  = 0;
        test_num   = 0;
        report_req = 1'b0;
        timed_out  = 1'b0;
        load_table();
        repeat (4) @(posedge clk);
        #1;
        rstn = 1'b1;
        for (int i = 0; i < op_q.size(); i++) begin
            if (!timed_out) begin
                run_entry(i);
            end
        end
        @(posedge clk);
        #1;
        report_req = 1'b1;
        @(negedge clk);
        #1;
        if (timed_out || error_count != 0 || tests_done != op_q.size()) begin
            $display("TEST FAILED");
        end else begin
            $display("TEST OK");
        end
        $finish;
    end

endmodule

//--- filelist.f
design/cache_pkg.sv
design/wb_pkg.sv
design/refill_counter.sv
design/tag_store.sv
design/line_store.sv
design/icache_ctrl.sv
design/icache_top.sv
test/icache_properties.sv
test/icache_checker.sv
test/icache_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= icache_tb
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert
PASS_STR  ?= TEST OK

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -qx "$(PASS_STR)" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
